//--- project.f
+incdir+hw
hw/capture_pkg.sv
hw/bb_pkg.sv
hw/sample_fifo.sv
hw/block_fill.sv
hw/block_drain.sv
hw/block_buffer.sv
hw/capture_top.sv
tests/capture_asserts.sv
tests/capture_tb.sv

//--- run.sh
#!/bin/sh
# compile the capture testbench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module capture_tb \
   -o capture_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/capture_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tests/capture_tb.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_tb;

   // each sample takes about two cycles to arrive and two to leave the stalling reader.
   localparam int RUN_CYCLES      = 4 * `FILL_THRESHOLD + 80;
   localparam int WATCHDOG_CYCLES = 10 * RUN_CYCLES;
   localparam int START_CYCLE     = 10;
   localparam int STALL_PERIOD    = 256;
   localparam int STALL_LENGTH    = 96;   // long enough to push the transmit FIFO past its high mark.

   logic                    write_clk;
   logic                    rst;
   logic                    spi_start_aq;
   logic                    sample_valid;
   capture_pkg::sample_t    sample;
   logic                    tx_read;
   capture_pkg::tx_word_t   tx_data;
   logic [`TX_ADDR_WIDTH:0] tx_count;
   logic                    aq_write_en;
   logic                    bb_filled;
   logic                    tx_ready_for_first_read;
   logic                    finished;
   bb_pkg::bb_addr_t        block_buffer_write_ptr;
   bb_pkg::bb_addr_t        block_buffer_read_ptr;
   logic [31:0]             lfsr_state;

   capture_top dut_i (
      .write_clk               (write_clk),
      .rst                     (rst),
      .spi_start_aq            (spi_start_aq),
      .sample_valid            (sample_valid),
      .sample                  (sample),
      .tx_read                 (tx_read),
      .tx_data                 (tx_data),
      .tx_count                (tx_count),
      .aq_write_en             (aq_write_en),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished),
      .block_buffer_write_ptr  (block_buffer_write_ptr),
      .block_buffer_read_ptr   (block_buffer_read_ptr)
   );

   bind capture_top capture_asserts asserts_i (
      .write_clk               (write_clk),
      .rst                     (rst),
      .spi_start_aq            (spi_start_aq),
      .sample_valid            (sample_valid),
      .aq_write_en             (aq_write_en),
      .aq_pop                  (aq_pop),
      .aq_count                (aq_count),
      .sample                  (sample),
      .tx_read                 (tx_read),
      .tx_data                 (tx_data),
      .tx_count                (tx_count),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished),
      .block_buffer_write_ptr  (block_buffer_write_ptr),
      .block_buffer_read_ptr   (block_buffer_read_ptr)
   );

   // ##########################################################################
   // random bits

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1.
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         bits       = {bits[30:0], lfsr_state[0]};
      end
   endtask

   task automatic report_check_failure();
      if (dut_i.asserts_i.err_is_value)
         $display("FAIL %s: expected %0h, actual %0h", dut_i.asserts_i.err_name,
                  dut_i.asserts_i.err_exp, dut_i.asserts_i.err_act);
      else
         $display("FAIL %s", dut_i.asserts_i.err_name);
      $display("Result: FAILED");
      $fatal(1, "stopping at the first failed check");
   endtask

   // ##########################################################################
   // clock, reset and stimulus

   initial
   begin
      write_clk = 1'b0;
      forever
         #50 write_clk = ~write_clk;
   end

   initial
   begin
      logic [31:0] bits;
      int          cycle;
      lfsr_state   = 32'ha7fc;
      cycle        = 0;
      rst          = 1'b1;
      spi_start_aq = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      tx_read      = 1'b0;
      repeat (3) @(posedge write_clk);
      rst <= 1'b0;
      forever
      begin
         @(posedge write_clk);
         cycle = cycle + 1;
         if (cycle >= START_CYCLE)
            spi_start_aq <= 1'b1;
         take_bits(1, bits);
         sample_valid <= bits[0];
         take_bits(`SAMPLE_WIDTH, bits);
         sample <= bits[`SAMPLE_WIDTH-1:0];
         take_bits(1, bits);
         // a pop issued at this edge is counted so the FIFO is never popped while empty.
         tx_read <= bits[0] && ((cycle % STALL_PERIOD) >= STALL_LENGTH) &&
                    (tx_count > (`TX_ADDR_WIDTH+1)'(tx_read));
      end
   end

   // ##########################################################################
   // watchdog and result

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge write_clk);
      $display("FAIL timeout: capture did not finish");
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      logic done_seen;
      done_seen = 1'b0;
      forever
      begin
         @(negedge write_clk);
         if (dut_i.asserts_i.err_flag)
            report_check_failure();
         else if (done_seen)
         begin
            $display("Result: PASSED");
            $finish;
         end
         else if (finished && (tx_count == '0))
            done_seen = 1'b1;  // one more edge lets the completion checks see the end state.
      end
   end

endmodule

//--- tests/capture_asserts.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_asserts (
   input logic                    write_clk,
   input logic                    rst,
   input logic                    spi_start_aq,
   input logic                    sample_valid,
   input logic                    aq_write_en,
   input logic                    aq_pop,
   input logic [`AQ_ADDR_WIDTH:0] aq_count,
   input capture_pkg::sample_t    sample,
   input logic                    tx_read,
   input capture_pkg::tx_word_t   tx_data,
   input logic [`TX_ADDR_WIDTH:0] tx_count,
   input logic                    bb_filled,
   input logic                    tx_ready_for_first_read,
   input logic                    finished,
   input bb_pkg::bb_addr_t        block_buffer_write_ptr,
   input bb_pkg::bb_addr_t        block_buffer_read_ptr
);

   localparam int                      OFS_WIDTH = $clog2(`BLOCKSIZE);
   localparam bb_pkg::bb_addr_t        FILL_END  = bb_pkg::bb_addr_t'(`FILL_THRESHOLD);
   localparam bb_pkg::bb_addr_t        BLOCK_END = bb_pkg::bb_addr_t'(`BLOCKSIZE);
   localparam logic [`TX_ADDR_WIDTH:0] TX_HIGH   = (`TX_ADDR_WIDTH+1)'(`TX_HIGH_MARK);
   localparam logic [`TX_ADDR_WIDTH:0] TX_LIMIT  = (`TX_ADDR_WIDTH+1)'(`TX_HIGH_MARK + 2);
   localparam logic [`AQ_ADDR_WIDTH:0] AQ_DEPTH  = (`AQ_ADDR_WIDTH+1)'(1 << `AQ_ADDR_WIDTH);

   capture_pkg::sample_t acc_mem [1024];  // every accepted sample, in arrival order.
   logic [9:0]           acc_cnt;
   logic [9:0]           move_cnt;
   logic [9:0]           pop_cnt;
   logic                 accepted;
   logic                 popping;
   capture_pkg::sample_t exp_sample;
   logic                 exp_start;
   logic                 err_flag     = 1'b0;
   logic                 err_is_value = 1'b0;
   string                err_name;
   logic [31:0]          err_exp;
   logic [31:0]          err_act;

   // a full FIFO drops the sample.
   assign accepted   = sample_valid && aq_write_en && (aq_count < AQ_DEPTH);
   assign popping    = tx_read && (tx_count != '0);
   assign exp_sample = acc_mem[pop_cnt];
   assign exp_start  = (pop_cnt[OFS_WIDTH-1:0] == '0);

   task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
      $error("%s: expected %0h, actual %0h", name, exp, act);
      if (!err_flag)
      begin
         err_name     = name;
         err_exp      = exp;
         err_act      = act;
         err_is_value = 1'b1;
         err_flag     = 1'b1;
      end
   endtask

   task automatic rule_error(input string what);
      $error("%s", what);
      if (!err_flag)
      begin
         err_name = what;
         err_flag = 1'b1;
      end
   endtask

   // ##########################################################################
   // scoreboard

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         acc_cnt  <= '0;
         move_cnt <= '0;
         pop_cnt  <= '0;
      end
      else
      begin
         if (accepted)
            acc_cnt <= acc_cnt + 1'b1;
         if (aq_pop)
            move_cnt <= move_cnt + 1'b1;  // each fill grant moves one sample out.
         if (popping)
            pop_cnt <= pop_cnt + 1'b1;
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (accepted)
         acc_mem[acc_cnt] <= sample;
   end

   // ##########################################################################
   // checks

   arm_timing: assert property (@(posedge write_clk) disable iff (rst)
      $rose(aq_write_en) |-> $past(spi_start_aq, 3) && !$past(spi_start_aq, 4))
      else rule_error("aq_write_en did not rise three edges after spi_start_aq");

   arm_early: assert property (@(posedge write_clk) disable iff (rst)
      aq_write_en |-> $past(spi_start_aq, 3))
      else rule_error("aq_write_en was high before spi_start_aq had passed the synchronizer");

   sticky_status: assert property (@(posedge write_clk) disable iff (rst)
      !$fell(aq_write_en) && !$fell(tx_ready_for_first_read) && !$fell(finished))
      else rule_error("a status output that must hold until reset went low");

   word_order: assert property (@(posedge write_clk) disable iff (rst)
      popping |-> tx_data.sample == exp_sample)
      else value_error("word order", 32'($sampled(exp_sample)), 32'($sampled(tx_data.sample)));

   block_framing: assert property (@(posedge write_clk) disable iff (rst)
      popping |-> tx_data.block_start == exp_start)
      else value_error("block start flag", 32'($sampled(exp_start)),
                       32'($sampled(tx_data.block_start)));

   write_bound: assert property (@(posedge write_clk) disable iff (rst)
      block_buffer_write_ptr <= FILL_END)
      else rule_error("write pointer went past the fill threshold");

   read_bound: assert property (@(posedge write_clk) disable iff (rst)
      block_buffer_read_ptr <= block_buffer_write_ptr)
      else rule_error("read pointer overtook the write pointer");

   filled_flag: assert property (@(posedge write_clk) disable iff (rst)
      bb_filled == (block_buffer_write_ptr >= BLOCK_END))
      else value_error("bb_filled", 32'($sampled(block_buffer_write_ptr >= BLOCK_END)),
                       32'($sampled(bb_filled)));

   tx_overshoot: assert property (@(posedge write_clk) disable iff (rst)
      tx_count <= TX_LIMIT)
      else rule_error("transmit count rose more than two above the high mark");

   ready_cause: assert property (@(posedge write_clk) disable iff (rst)
      $rose(tx_ready_for_first_read) |-> $past(tx_count) > TX_HIGH)
      else rule_error("tx_ready_for_first_read rose before the high mark was passed");

   finish_point: assert property (@(posedge write_clk) disable iff (rst)
      $rose(finished) |-> block_buffer_read_ptr == FILL_END)
      else value_error("read pointer at finish", 32'(FILL_END),
                       32'($sampled(block_buffer_read_ptr)));

   word_total: assert property (@(posedge write_clk) disable iff (rst)
      (finished && (tx_count == '0)) |-> pop_cnt == 10'(`FILL_THRESHOLD))
      else value_error("words read out", 32'(`FILL_THRESHOLD), 32'($sampled(pop_cnt)));

   aq_depth: assert property (@(posedge write_clk) disable iff (rst)
      (acc_cnt - move_cnt) <= 10'(1 << `AQ_ADDR_WIDTH))
      else rule_error("acquisition FIFO held more samples than its depth");

endmodule

//--- hw/capture_top.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_top (
   input  logic                    write_clk,
   input  logic                    rst,
   input  logic                    spi_start_aq,
   input  logic                    sample_valid,
   input  capture_pkg::sample_t    sample,
   input  logic                    tx_read,
   output capture_pkg::tx_word_t   tx_data,
   output logic [`TX_ADDR_WIDTH:0] tx_count,
   output logic                    aq_write_en,
   output logic                    bb_filled,
   output logic                    tx_ready_for_first_read,
   output logic                    finished,
   output bb_pkg::bb_addr_t        block_buffer_write_ptr,
   output bb_pkg::bb_addr_t        block_buffer_read_ptr
);

   logic                    aq_push;
   logic                    aq_pop;
   logic [`AQ_ADDR_WIDTH:0] aq_count;
   capture_pkg::sample_t    aq_head;
   bb_pkg::bb_req_t         fill_req;
   bb_pkg::bb_req_t         drain_req;
   logic                    fill_gnt;
   logic                    drain_gnt;
   logic                    rd_valid;
   capture_pkg::sample_t    rd_data;
   logic                    tx_push;
   capture_pkg::tx_word_t   tx_word;

   sample_fifo #(
      .T          (capture_pkg::sample_t),
      .ADDR_WIDTH (`AQ_ADDR_WIDTH)
   ) aq_fifo_i (
      .write_clk (write_clk),
      .rst       (rst),
      .push      (aq_push),
      .in_data   (sample),
      .pop       (aq_pop),
      .out_data  (aq_head),
      .count     (aq_count)
   );

   block_fill fill_i (
      .write_clk    (write_clk),
      .rst          (rst),
      .spi_start_aq (spi_start_aq),
      .sample_valid (sample_valid),
      .aq_push      (aq_push),
      .aq_write_en  (aq_write_en),
      .aq_count     (aq_count),
      .aq_head      (aq_head),
      .aq_pop       (aq_pop),
      .fill_req     (fill_req),
      .fill_gnt     (fill_gnt),
      .write_ptr    (block_buffer_write_ptr)
   );

   block_buffer bb_i (
      .write_clk (write_clk),
      .rst       (rst),
      .fill_req  (fill_req),
      .drain_req (drain_req),
      .fill_gnt  (fill_gnt),
      .drain_gnt (drain_gnt),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data)
   );

   block_drain drain_i (
      .write_clk               (write_clk),
      .rst                     (rst),
      .write_ptr               (block_buffer_write_ptr),
      .drain_req               (drain_req),
      .drain_gnt               (drain_gnt),
      .rd_valid                (rd_valid),
      .rd_data                 (rd_data),
      .tx_push                 (tx_push),
      .tx_word                 (tx_word),
      .tx_count                (tx_count),
      .read_ptr                (block_buffer_read_ptr),
      .bb_filled               (bb_filled),
      .tx_ready_for_first_read (tx_ready_for_first_read),
      .finished                (finished)
   );

   sample_fifo #(
      .T          (capture_pkg::tx_word_t),
      .ADDR_WIDTH (`TX_ADDR_WIDTH)
   ) tx_fifo_i (
      .write_clk (write_clk),
      .rst       (rst),
      .push      (tx_push),
      .in_data   (tx_word),
      .pop       (tx_read),
      .out_data  (tx_data),
      .count     (tx_count)
   );

endmodule

//--- hw/block_buffer.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module block_buffer (
   input  logic                 write_clk,
   input  logic                 rst,
   input  bb_pkg::bb_req_t      fill_req,
   input  bb_pkg::bb_req_t      drain_req,
   output logic                 fill_gnt,
   output logic                 drain_gnt,
   output logic                 rd_valid,
   output capture_pkg::sample_t rd_data
);

   localparam int DEPTH = 1 << `BB_ADDR_WIDTH;

   capture_pkg::sample_t mem [DEPTH];
   logic                 last_fill;
   logic                 any_gnt;
   bb_pkg::bb_req_t      sel;

   // ##########################################################################
   // round-robin arbiter

   // on a tie the requester that was not served last time wins.
   assign fill_gnt  = fill_req.req & (~drain_req.req | ~last_fill);
   assign drain_gnt = drain_req.req & ~fill_gnt;
   assign any_gnt   = fill_gnt | drain_gnt;
   assign sel       = fill_gnt ? fill_req : drain_req;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         last_fill <= 1'b0;
         rd_valid  <= 1'b0;
      end
      else
      begin
         rd_valid <= any_gnt & ~sel.we;  // read data is registered one cycle after the grant.
         if (any_gnt)
            last_fill <= fill_gnt;
      end
   end

   // ##########################################################################
   // single-port RAM

   always_ff @(posedge write_clk)
   begin
      if (any_gnt)
      begin
         if (sel.we)
            mem[sel.addr] <= sel.data;
         else
            rd_data <= mem[sel.addr];
      end
   end

endmodule

//--- hw/block_drain.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module block_drain (
   input  logic                    write_clk,
   input  logic                    rst,
   input  bb_pkg::bb_addr_t        write_ptr,
   output bb_pkg::bb_req_t         drain_req,
   input  logic                    drain_gnt,
   input  logic                    rd_valid,
   input  capture_pkg::sample_t    rd_data,
   output logic                    tx_push,
   output capture_pkg::tx_word_t   tx_word,
   input  logic [`TX_ADDR_WIDTH:0] tx_count,
   output bb_pkg::bb_addr_t        read_ptr,
   output logic                    bb_filled,
   output logic                    tx_ready_for_first_read,
   output logic                    finished
);

   localparam int OFS_WIDTH = $clog2(`BLOCKSIZE);

   typedef enum logic [1:0] {
      st_writing,
      st_idle,
      st_finished
   } drain_state_t;

   drain_state_t state;
   logic         req_q;
   logic         in_flight;
   logic         start_q;
   logic         can_issue;
   logic         last_valid;

   assign bb_filled  = (write_ptr >= `BLOCKSIZE);
   assign can_issue  = (state == st_writing) && bb_filled && !in_flight &&
                       (read_ptr < write_ptr) && (read_ptr < `FILL_THRESHOLD);
   assign last_valid = rd_valid && (read_ptr == `FILL_THRESHOLD);

   // ##########################################################################
   // read requests, one in flight at most

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         req_q     <= 1'b0;
         in_flight <= 1'b0;
         read_ptr  <= '0;
      end
      else
      begin
         if (req_q)
         begin
            if (drain_gnt)
            begin
               req_q     <= 1'b0;
               in_flight <= 1'b1;
               read_ptr  <= read_ptr + 1'b1;
            end
         end
         else if (can_issue)
            req_q <= 1'b1;  // once raised the request is held even if draining pauses.
         if (rd_valid)
            in_flight <= 1'b0;
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (drain_gnt)
         start_q <= (read_ptr[OFS_WIDTH-1:0] == '0);
   end

   // ##########################################################################
   // transmit level hysteresis

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state                   <= st_writing;
         tx_ready_for_first_read <= 1'b0;
      end
      else
      begin
         case (state)
            st_writing:
               if (last_valid)
                  state <= st_finished;
               else if (tx_count > `TX_HIGH_MARK)
               begin
                  state                   <= st_idle;
                  tx_ready_for_first_read <= 1'b1;
               end
            st_idle:
               if (last_valid)
                  state <= st_finished;
               else if (tx_count < `TX_LOW_MARK)
                  state <= st_writing;
            default:
               state <= st_finished;
         endcase
      end
   end

   assign finished  = (state == st_finished);
   assign tx_push   = rd_valid;
   assign tx_word   = '{block_start: start_q, sample: rd_data};
   assign drain_req = '{req: req_q, we: 1'b0, addr: read_ptr, data: '0};

endmodule

//--- hw/block_fill.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module block_fill (
   input  logic                    write_clk,
   input  logic                    rst,
   input  logic                    spi_start_aq,
   input  logic                    sample_valid,
   output logic                    aq_push,
   output logic                    aq_write_en,
   input  logic [`AQ_ADDR_WIDTH:0] aq_count,
   input  capture_pkg::sample_t    aq_head,
   output logic                    aq_pop,
   output bb_pkg::bb_req_t         fill_req,
   input  logic                    fill_gnt,
   output bb_pkg::bb_addr_t        write_ptr
);

   localparam int CNT_WIDTH = $clog2(`BLOCKSIZE);

   typedef enum logic {
      st_waiting,
      st_moving
   } fill_state_t;

   logic [1:0]           start_sync;
   fill_state_t          state;
   logic [CNT_WIDTH-1:0] word_cnt;

   // ##########################################################################
   // start level synchronizer and capture arming

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         start_sync  <= 2'b00;
         aq_write_en <= 1'b0;
      end
      else
      begin
         start_sync <= {start_sync[0], spi_start_aq};
         if (start_sync[1])
            aq_write_en <= 1'b1;  // stays armed until the next reset.
      end
   end

   assign aq_push = sample_valid & aq_write_en;

   // ##########################################################################
   // block moves from the acquisition FIFO into the block buffer

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= st_waiting;
         write_ptr <= '0;
         word_cnt  <= '0;
      end
      else
      begin
         case (state)
            st_waiting:
               if ((aq_count >= `BLOCKSIZE) && (write_ptr < `FILL_THRESHOLD))
               begin
                  state    <= st_moving;
                  word_cnt <= '0;
               end
            st_moving:
               if (fill_gnt)
               begin
                  write_ptr <= write_ptr + 1'b1;
                  word_cnt  <= word_cnt + 1'b1;
                  if (word_cnt == CNT_WIDTH'(`BLOCKSIZE - 1))
                     state <= st_waiting;  // the whole block is in the buffer.
               end
            default:
               state <= st_waiting;
         endcase
      end
   end

   // the FIFO head is the write data and only moves on a grant.
   assign aq_pop   = fill_gnt;
   assign fill_req = '{req: (state == st_moving), we: 1'b1, addr: write_ptr, data: aq_head};

endmodule

//--- hw/sample_fifo.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module sample_fifo #(
   parameter type T          = logic,
   parameter int  ADDR_WIDTH = 4
) (
   input  logic                write_clk,
   input  logic                rst,
   input  logic                push,
   input  T                    in_data,
   input  logic                pop,
   output T                    out_data,
   output logic [ADDR_WIDTH:0] count
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   T                      mem [DEPTH];
   logic [ADDR_WIDTH-1:0] wr_ptr;
   logic [ADDR_WIDTH-1:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push && (count < (ADDR_WIDTH+1)'(DEPTH));  // push while full is dropped.
   assign do_pop  = pop && (count != '0);

   assign out_data = mem[rd_ptr];  // head is visible as soon as count is non-zero.

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= in_data;
   end

endmodule

//--- hw/bb_pkg.sv
`include "capture_defines.svh"

package bb_pkg;

   typedef logic [`BB_ADDR_WIDTH-1:0] bb_addr_t;

   // a request is held with stable fields until its grant pulse.
   typedef struct packed
   {
      logic                 req;
      logic                 we;
      bb_addr_t             addr;
      capture_pkg::sample_t data;
   } bb_req_t;

endpackage

//--- hw/capture_pkg.sv
`include "capture_defines.svh"

package capture_pkg;

   // one antenna sample as delivered by the digitizer.
   typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

   typedef struct packed
   {
      logic    block_start;  // set on the first sample of each block.
      sample_t sample;
   } tx_word_t;

endpackage

//--- hw/capture_defines.svh
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// ##########################################################################
// sample and block sizes

`define SAMPLE_WIDTH    24
`define BLOCKSIZE       32

// ##########################################################################
// block buffer, 512 words, filled up to one block short of the top

`define BB_ADDR_WIDTH   9
`define FILL_THRESHOLD  ((1 << `BB_ADDR_WIDTH) - `BLOCKSIZE)

// ##########################################################################
// FIFO depths and transmit hysteresis

`define AQ_ADDR_WIDTH   7
`define TX_ADDR_WIDTH   5
`define TX_HIGH_MARK    15  // draining pauses above this level.
`define TX_LOW_MARK     5   // draining resumes below this level.

`endif
